// File: build.f
fetchPkg.sv
instrRom.sv
branchTargetBuffer.sv
programCounter.sv
fetchUnit.sv
fetchTb.sv

// File: Bender.yml
package:
  name: fetchUnit

sources:
  - fetchPkg.sv
  - instrRom.sv
  - branchTargetBuffer.sv
  - programCounter.sv
  - fetchUnit.sv
  - target: simulation
    files:
      - fetchTb.sv

// File: fetchTb.sv
module fetchTb;

    localparam int btbLog2 = 4;
    localparam int imemLog2 = 6;
    localparam int period = 40;
    // Cycle counts of reset, memory load, the six tests and a margin
    localparam int timeoutCycles = 17 + 65 + 12 + 6 + 16 + 14 + 20 + 20;

    logic clk;
    logic rst;
    logic en0;
    logic en1;
    logic redirect;
    logic btbWrite;
    logic btbIsJump;
    logic btbMultiple;
    logic imemWrite;
    logic [imemLog2-1:0] imemAddr;
    fetchPkg::bundleT imemData;
    fetchPkg::addrT redirectPc;
    fetchPkg::addrT btbSrc;
    fetchPkg::addrT btbDst;
    fetchPkg::addrT pcRaw;
    fetchPkg::addrT slotPc [fetchPkg::fetchWidth];
    fetchPkg::instrT slotInstr [fetchPkg::fetchWidth];
    fetchPkg::branchIdT slotBranchId [fetchPkg::fetchWidth];
    logic slotPred [fetchPkg::fetchWidth];
    logic slotValid [fetchPkg::fetchWidth];

    // Reference model state
    fetchPkg::bundleT refMem [2**imemLog2];
    logic btbValid [2**btbLog2];
    fetchPkg::addrT btbSrcRef [2**btbLog2];
    fetchPkg::addrT btbDstRef [2**btbLog2];
    logic btbJumpRef [2**btbLog2];
    logic btbMultRef [2**btbLog2];
    fetchPkg::addrT mPc;
    fetchPkg::addrT mPcLast;
    logic [1:0] mMask;
    fetchPkg::branchIdT mId [fetchPkg::fetchWidth];
    logic mPred [fetchPkg::fetchWidth];
    fetchPkg::bundleT mBundle;
    fetchPkg::addrT expPc [fetchPkg::fetchWidth];
    fetchPkg::instrT expInstr [fetchPkg::fetchWidth];
    fetchPkg::branchIdT expId [fetchPkg::fetchWidth];
    logic expPred [fetchPkg::fetchWidth];
    logic expValid [fetchPkg::fetchWidth];

    int errors;
    int checks;
    int seed;

    fetchUnit #(
        .btbEntriesLog2(btbLog2),
        .imemDepthLog2 (imemLog2)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Advances the model by one edge using the inputs the DUT sees at that edge
    task automatic updateModel();
        int idx;
        logic hitRef;
        logic srcSlot;
        fetchPkg::addrT nPc;
        logic [1:0] nMask;
        fetchPkg::branchIdT nId [fetchPkg::fetchWidth];
        logic nPred [fetchPkg::fetchWidth];
        if (imemWrite) begin
            refMem[imemAddr] = imemData;
        end
        if (rst) begin
            mPc = '0;
            mPcLast = '0;
            mMask = '0;
            for (int i = 0; i < 2**btbLog2; i++) begin
                btbValid[i] = 1'b0;
            end
            for (int i = 0; i < fetchPkg::fetchWidth; i++) begin
                mId[i] = fetchPkg::noBranchId;
                mPred[i] = 1'b0;
                expValid[i] = 1'b0;
            end
        end else begin
            if (en1 && !redirect) begin
                for (int i = 0; i < fetchPkg::fetchWidth; i++) begin
                    expValid[i] = (i >= mPcLast[2]) && mMask[i];
                    expPc[i] = {mPcLast[31:3], i[0], 2'b00};
                    expInstr[i] = mBundle[32*i +: 32];
                    expId[i] = mId[i];
                    expPred[i] = mPred[i];
                end
            end
            if (redirect) begin
                mPc = redirectPc;
            end else if (en0) begin
                idx = mPc[btbLog2+2:3];
                srcSlot = btbSrcRef[idx][2];
                hitRef = btbValid[idx] && (btbSrcRef[idx][31:3] == mPc[31:3])
                         && (srcSlot >= mPc[2]);
                nPc = mPc + (mPc[2] ? 4 : 8);
                nMask = 2'b11;
                for (int i = 0; i < fetchPkg::fetchWidth; i++) begin
                    nId[i] = fetchPkg::noBranchId;
                    nPred[i] = 1'b0;
                end
                if (hitRef) begin
                    nId[srcSlot] = fetchPkg::branchIdT'(idx);
                    if (btbJumpRef[idx]) begin
                        nPc = btbDstRef[idx];
                        nPred[srcSlot] = 1'b1;
                        nMask = srcSlot ? 2'b11 : 2'b01;
                    end else if (btbMultRef[idx]) begin
                        nPc = btbSrcRef[idx] + 4;
                        nMask = 2'b01;
                    end
                end
                mBundle = refMem[mPc[imemLog2+2:3]];
                mPcLast = mPc;
                mMask = nMask;
                mId = nId;
                mPred = nPred;
                mPc = nPc;
            end
            if (btbWrite) begin
                idx = btbSrc[btbLog2+2:3];
                btbValid[idx] = 1'b1;
                btbSrcRef[idx] = btbSrc;
                btbDstRef[idx] = btbDst;
                btbJumpRef[idx] = btbIsJump;
                btbMultRef[idx] = btbMultiple;
            end
        end
    endtask

    task automatic checkSlots();
        compare("pcRaw", pcRaw, mPc);
        for (int i = 0; i < fetchPkg::fetchWidth; i++) begin
            compare($sformatf("slotValid[%0d]", i), slotValid[i], expValid[i]);
            if (expValid[i]) begin
                compare($sformatf("slotPc[%0d]", i), slotPc[i], expPc[i]);
                compare($sformatf("slotInstr[%0d]", i), slotInstr[i], expInstr[i]);
                compare($sformatf("slotBranchId[%0d]", i), slotBranchId[i], expId[i]);
                compare($sformatf("slotPred[%0d]", i), slotPred[i], expPred[i]);
            end
        end
    endtask

    // Rising edge, model update, strobes dropped unless the caller sets them again
    task automatic stepEdge();
        @(posedge clk);
        updateModel();
        btbWrite <= 1'b0;
        imemWrite <= 1'b0;
    endtask

    task automatic runCycle(input logic e0, input logic e1, input logic rd,
                            input fetchPkg::addrT rdPc);
        stepEdge();
        en0 <= e0;
        en1 <= e1;
        redirect <= rd;
        redirectPc <= rdPc;
        @(negedge clk);
        checkSlots();
    endtask

    task automatic writeBtb(input fetchPkg::addrT src, input fetchPkg::addrT dst,
                            input logic jump, input logic mult);
        stepEdge();
        en0 <= 1'b0;
        en1 <= 1'b0;
        redirect <= 1'b0;
        btbWrite <= 1'b1;
        btbSrc <= src;
        btbDst <= dst;
        btbIsJump <= jump;
        btbMultiple <= mult;
        @(negedge clk);
        checkSlots();
    endtask

    task automatic loadMemory();
        fetchPkg::bundleT data;
        for (int i = 0; i < 2**imemLog2; i++) begin
            data[31:0] = $random(seed);
            data[63:32] = $random(seed);
            stepEdge();
            imemWrite <= 1'b1;
            imemAddr <= i[imemLog2-1:0];
            imemData <= data;
        end
    endtask

    task automatic resetAndSequentialTest();
        repeat (16) stepEdge();
        rst <= 1'b0;
        @(negedge clk);
        compare("pcRaw", pcRaw, 32'h0);
        compare("slotValid[0]", slotValid[0], 1'b0);
        compare("slotValid[1]", slotValid[1], 1'b0);
        loadMemory();
        repeat (11) runCycle(1'b1, 1'b1, 1'b0, '0);
    endtask

    task automatic redirectSlot1Test();
        runCycle(1'b1, 1'b1, 1'b1, 32'h64);
        repeat (5) runCycle(1'b1, 1'b1, 1'b0, '0);
    endtask

    task automatic jumpTest();
        writeBtb(32'h10c, 32'h40, 1'b1, 1'b0);
        writeBtb(32'h80, 32'h124, 1'b1, 1'b0);
        runCycle(1'b1, 1'b1, 1'b1, 32'h108);
        repeat (6) runCycle(1'b1, 1'b1, 1'b0, '0);
        runCycle(1'b1, 1'b1, 1'b1, 32'h80);
        repeat (6) runCycle(1'b1, 1'b1, 1'b0, '0);
    endtask

    task automatic branchTest(input fetchPkg::addrT src, input logic mult);
        writeBtb(src, 32'h1f0, 1'b0, mult);
        runCycle(1'b1, 1'b1, 1'b1, {src[31:3], 3'b000});
        repeat (5) runCycle(1'b1, 1'b1, 1'b0, '0);
    endtask

    task automatic stallTest();
        runCycle(1'b1, 1'b1, 1'b1, 32'h20);
        repeat (3) runCycle(1'b1, 1'b1, 1'b0, '0);
        repeat (4) runCycle(1'b0, 1'b1, 1'b0, '0);
        repeat (4) runCycle(1'b1, 1'b0, 1'b0, '0);
        repeat (2) runCycle(1'b0, 1'b0, 1'b0, '0);
        repeat (4) runCycle(1'b1, 1'b1, 1'b0, '0);
    endtask

    initial begin
        #(timeoutCycles * period);
        $display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        seed = 32'hfd00;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        en0 = 1'b0;
        en1 = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        btbWrite = 1'b0;
        btbSrc = '0;
        btbDst = '0;
        btbIsJump = 1'b0;
        btbMultiple = 1'b0;
        imemWrite = 1'b0;
        imemAddr = '0;
        imemData = '0;
        resetAndSequentialTest();
        redirectSlot1Test();
        jumpTest();
        // Branch in slot 0 followed by another, then a lone branch in slot 1
        branchTest(32'h150, 1'b1);
        branchTest(32'h1a4, 1'b0);
        stallTest();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: fetchUnit.sv
module fetchUnit #(
    parameter int btbEntriesLog2 = 4,
    parameter int imemDepthLog2  = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     en0,
    input  logic                     en1,
    input  logic                     redirect,
    input  fetchPkg::addrT           redirectPc,
    input  logic                     btbWrite,
    input  fetchPkg::addrT           btbSrc,
    input  fetchPkg::addrT           btbDst,
    input  logic                     btbIsJump,
    input  logic                     btbMultiple,
    input  logic                     imemWrite,
    input  logic [imemDepthLog2-1:0] imemAddr,
    input  fetchPkg::bundleT         imemData,
    output fetchPkg::addrT           pcRaw,
    output fetchPkg::addrT           slotPc [fetchPkg::fetchWidth],
    output fetchPkg::instrT          slotInstr [fetchPkg::fetchWidth],
    output fetchPkg::branchIdT       slotBranchId [fetchPkg::fetchWidth],
    output logic                     slotPred [fetchPkg::fetchWidth],
    output logic                     slotValid [fetchPkg::fetchWidth]
);

    fetchPkg::bundleT   bundle;
    logic               hit;
    fetchPkg::addrT     src;
    fetchPkg::addrT     dst;
    logic               isJump;
    logic               multiple;
    fetchPkg::branchIdT id;

    // Memory read holds on a redirect edge just like the latched fetch state
    instrRom #(
        .imemDepthLog2(imemDepthLog2)
    ) rom (
        .clk      (clk),
        .en0      (en0 && !redirect),
        .pc       (pcRaw),
        .imemWrite(imemWrite),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .bundle   (bundle)
    );

    branchTargetBuffer #(
        .btbEntriesLog2(btbEntriesLog2)
    ) btb (
        .clk        (clk),
        .rst        (rst),
        .pc         (pcRaw),
        .btbWrite   (btbWrite),
        .btbSrc     (btbSrc),
        .btbDst     (btbDst),
        .btbIsJump  (btbIsJump),
        .btbMultiple(btbMultiple),
        .hit        (hit),
        .src        (src),
        .dst        (dst),
        .isJump     (isJump),
        .multiple   (multiple),
        .id         (id)
    );

    programCounter pcUnit (
        .clk         (clk),
        .rst         (rst),
        .en0         (en0),
        .en1         (en1),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .bundle      (bundle),
        .hit         (hit),
        .src         (src),
        .dst         (dst),
        .isJump      (isJump),
        .multiple    (multiple),
        .id          (id),
        .pc          (pcRaw),
        .slotPc      (slotPc),
        .slotInstr   (slotInstr),
        .slotBranchId(slotBranchId),
        .slotPred    (slotPred),
        .slotValid   (slotValid)
    );

endmodule

// File: programCounter.sv
module programCounter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 en0,
    input  logic                 en1,
    input  logic                 redirect,
    input  fetchPkg::addrT       redirectPc,
    input  fetchPkg::bundleT     bundle,
    input  logic                 hit,
    input  fetchPkg::addrT       src,
    input  fetchPkg::addrT       dst,
    input  logic                 isJump,
    input  logic                 multiple,
    input  fetchPkg::branchIdT   id,
    output fetchPkg::addrT       pc,
    output fetchPkg::addrT       slotPc [fetchPkg::fetchWidth],
    output fetchPkg::instrT      slotInstr [fetchPkg::fetchWidth],
    output fetchPkg::branchIdT   slotBranchId [fetchPkg::fetchWidth],
    output logic                 slotPred [fetchPkg::fetchWidth],
    output logic                 slotValid [fetchPkg::fetchWidth]
);

    typedef logic [fetchPkg::fetchWidth-1:0] maskT;

    fetchPkg::addrT     seqPc;
    fetchPkg::addrT     nextPc;
    maskT               nextMask;
    fetchPkg::branchIdT nextId [fetchPkg::fetchWidth];
    logic               nextPred [fetchPkg::fetchWidth];

    // Fetch information latched for the slot output stage
    fetchPkg::addrT     pcLast;
    maskT               maskLast;
    fetchPkg::branchIdT idLast [fetchPkg::fetchWidth];
    logic               predLast [fetchPkg::fetchWidth];

    // Next bundle base is +8 from slot 0 and +4 from slot 1
    assign seqPc = {pc[31:3], 3'b000} + 32'd8;

    always_comb begin
        nextPc   = seqPc;
        nextMask = '1;
        for (int i = 0; i < fetchPkg::fetchWidth; i++) begin
            nextId[i]   = fetchPkg::noBranchId;
            nextPred[i] = 1'b0;
        end

        if (hit) begin
            nextId[src[2]] = id;
            if (isJump) begin
                nextPc           = dst;
                nextPred[src[2]] = 1'b1;
                // Slot 1 is dead when the jump sits in slot 0
                if (!src[2]) begin
                    nextMask = 2'b01;
                end
            end else if (multiple) begin
                // Another branch follows in this bundle and is fetched next
                nextPc   = src + 32'd4;
                nextMask = 2'b01;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            pcLast   <= '0;
            maskLast <= '0;
            for (int i = 0; i < fetchPkg::fetchWidth; i++) begin
                idLast[i]   <= fetchPkg::noBranchId;
                predLast[i] <= 1'b0;
            end
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (en0) begin
            pc       <= nextPc;
            pcLast   <= pc;
            maskLast <= nextMask;
            idLast   <= nextId;
            predLast <= nextPred;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fetchPkg::fetchWidth; i++) begin
                slotValid[i] <= 1'b0;
            end
        end else if (en1 && !redirect) begin
            for (int i = 0; i < fetchPkg::fetchWidth; i++) begin
                slotValid[i] <= (i >= int'(pcLast[2])) && maskLast[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en1 && !redirect) begin
            for (int i = 0; i < fetchPkg::fetchWidth; i++) begin
                slotPc[i]       <= {pcLast[31:3], 3'b000} + 32'(4 * i);
                slotInstr[i]    <= bundle[32*i +: 32];
                slotBranchId[i] <= idLast[i];
                slotPred[i]     <= predLast[i];
            end
        end
    end

endmodule

// File: branchTargetBuffer.sv
module branchTargetBuffer #(
    parameter int btbEntriesLog2 = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  fetchPkg::addrT       pc,
    input  logic                 btbWrite,
    input  fetchPkg::addrT       btbSrc,
    input  fetchPkg::addrT       btbDst,
    input  logic                 btbIsJump,
    input  logic                 btbMultiple,
    output logic                 hit,
    output fetchPkg::addrT       src,
    output fetchPkg::addrT       dst,
    output logic                 isJump,
    output logic                 multiple,
    output fetchPkg::branchIdT   id
);

    localparam int entries = 2 ** btbEntriesLog2;
    // Bundle address bits above the index
    localparam int tagW = 32 - 3 - btbEntriesLog2;

    typedef logic [btbEntriesLog2-1:0] idxT;
    typedef logic [tagW-1:0] tagT;

    logic [entries-1:0] entryValid;
    tagT                entryTag [entries];
    logic               entrySlot [entries];
    fetchPkg::addrT     entryDst [entries];
    logic               entryJump [entries];
    logic               entryMultiple [entries];

    idxT lookupIdx;
    tagT lookupTag;
    idxT writeIdx;
    tagT writeTag;

    assign lookupIdx = pc[btbEntriesLog2+2:3];
    assign lookupTag = pc[31:btbEntriesLog2+3];
    assign writeIdx  = btbSrc[btbEntriesLog2+2:3];
    assign writeTag  = btbSrc[31:btbEntriesLog2+3];

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (btbWrite) begin
            entryValid[writeIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btbWrite) begin
            entryTag[writeIdx]      <= writeTag;
            entrySlot[writeIdx]     <= btbSrc[2];
            entryDst[writeIdx]      <= btbDst;
            entryJump[writeIdx]     <= btbIsJump;
            entryMultiple[writeIdx] <= btbMultiple;
        end
    end

    // A source before the fetch slot was already passed, so it does not count
    assign hit = entryValid[lookupIdx]
                 && (entryTag[lookupIdx] == lookupTag)
                 && (entrySlot[lookupIdx] >= pc[2]);

    assign src      = {entryTag[lookupIdx], lookupIdx, entrySlot[lookupIdx], 2'b00};
    assign dst      = entryDst[lookupIdx];
    assign isJump   = entryJump[lookupIdx];
    assign multiple = entryMultiple[lookupIdx];
    assign id       = fetchPkg::branchIdT'(lookupIdx);

endmodule

// File: instrRom.sv
module instrRom #(
    parameter int imemDepthLog2 = 6
) (
    input  logic                     clk,
    input  logic                     en0,
    input  fetchPkg::addrT           pc,
    input  logic                     imemWrite,
    input  logic [imemDepthLog2-1:0] imemAddr,
    input  fetchPkg::bundleT         imemData,
    output fetchPkg::bundleT         bundle
);

    localparam int depth = 2 ** imemDepthLog2;

    fetchPkg::bundleT mem [depth];

    logic [imemDepthLog2-1:0] readIdx;

    // Bits 2:0 address within the bundle
    assign readIdx = pc[imemDepthLog2+2:3];

    always_ff @(posedge clk) begin
        if (imemWrite) begin
            mem[imemAddr] <= imemData;
        end
    end

    // Read lines up with the counter's latched fetch address
    always_ff @(posedge clk) begin
        if (en0) begin
            bundle <= mem[readIdx];
        end
    end

endmodule

// File: fetchPkg.sv
package fetchPkg;

    // Byte address where bit 2 picks the slot inside a bundle
    typedef logic [31:0] addrT;

    typedef logic [31:0] instrT;

    // Two instructions with the lower address in the low half
    typedef logic [63:0] bundleT;

    // Holds the BTB entry index of a branch
    typedef logic [5:0] branchIdT;

    localparam branchIdT noBranchId = 6'd63;

    // Instruction slots per bundle
    localparam int fetchWidth = 2;

endpackage
